// File: hw/decode_pkg.sv
package decode_pkg;

  // rv32 base opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    R_TYPE = 7'b0110011,
    I_TYPE = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    B_TYPE = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011,
    AMO    = 7'b0101111
  } opcode_e;

  // alu class handed to execute
  typedef enum logic [1:0] {
    ALU_LOAD_STORE = 2'b00,
    ALU_I_TYPE     = 2'b01,
    ALU_B_TYPE     = 2'b10,
    ALU_R_TYPE     = 2'b11
  } alu_op_e;

  // format views, msb first, fields at their isa positions
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset is scattered, bit 0 implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one 32-bit word, six ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  // main control word, 16 bits
  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    // 00 alu, 01 load data, 10 csr read
    logic [1:0] mem_csr_to_reg;
    logic       branch;
    logic       alu_src;
    logic       jump;
    alu_op_e    alu_op;
    logic       lui;
    logic       auipc;
    logic       jal;
    logic       r_type;
    logic       csr_type;
    logic       is_atomic;
    logic       invalid_inst;
  } ctrl_t;

  // fetch packet, one queue entry
  typedef struct packed {
    logic [31:0] pc;
    instr_u      instr;
  } fetch_t;

  // micro-op toward execute
  typedef struct packed {
    logic [31:0] pc;
    ctrl_t       ctrl;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
  } uop_t;

endpackage : decode_pkg

// File: hw/decode_control.sv
`timescale 1ns/1ps

module decode_control (
  input  logic [6:0]          opcode,
  output decode_pkg::ctrl_t   ctrl
);

  import decode_pkg::*;

  always_comb begin
    // everything off unless the opcode turns it on
    ctrl = '0;
    case (opcode)
      R_TYPE: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_R_TYPE;
        ctrl.r_type    = 1'b1;
      end
      I_TYPE: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_I_TYPE;
        ctrl.alu_src   = 1'b1;
      end
      JALR: begin
        // target rs1 + imm with link into rd
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_LOAD_STORE;
        ctrl.alu_src   = 1'b1;
        ctrl.jump      = 1'b1;
      end
      LOAD: begin
        ctrl.reg_write      = 1'b1;
        ctrl.mem_csr_to_reg = 2'b01;
        ctrl.alu_op         = ALU_LOAD_STORE;
        ctrl.alu_src        = 1'b1;
      end
      STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_op    = ALU_LOAD_STORE;
        ctrl.alu_src   = 1'b1;
      end
      B_TYPE: begin
        // compare rs1 with rs2 without writeback
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_B_TYPE;
      end
      JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_LOAD_STORE;
        ctrl.alu_src   = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.jal       = 1'b1;
      end
      LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_LOAD_STORE;
        ctrl.alu_src   = 1'b1;
        ctrl.lui       = 1'b1;
      end
      AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_LOAD_STORE;
        ctrl.alu_src   = 1'b1;
        ctrl.auipc     = 1'b1;
      end
      SYSTEM: begin
        // csr ops and mret take their result from the csr file
        ctrl.reg_write      = 1'b1;
        ctrl.mem_csr_to_reg = 2'b10;
        ctrl.alu_op         = ALU_R_TYPE;
        ctrl.csr_type       = 1'b1;
      end
      AMO: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_LOAD_STORE;
        ctrl.is_atomic = 1'b1;
      end
      default: begin
        // flag an unknown opcode and leave state untouched
        ctrl.invalid_inst = 1'b1;
      end
    endcase
  end

endmodule : decode_control

// File: hw/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
  input  decode_pkg::instr_u instr,
  output logic [31:0]        imm
);

  import decode_pkg::*;

  always_comb begin
    imm = '0;
    // opcode sits at the same place in every view
    case (instr.r_fmt.opcode)
      I_TYPE, LOAD, JALR, SYSTEM: begin
        imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
      end
      STORE: begin
        imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
      end
      B_TYPE: begin
        // halfword offset, lsb always zero
        imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
               instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
      end
      LUI, AUIPC: begin
        imm = {instr.u_fmt.imm_31_12, 12'b0};
      end
      JAL: begin
        imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
               instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
      end
      // r-type, amo and unknown carry no immediate
      default: imm = '0;
    endcase
  end

endmodule : imm_gen

// File: hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  decode_pkg::fetch_t push_data,
  input  logic               pop,
  output decode_pkg::fetch_t head,
  output logic               not_empty,
  output logic               credit
);

  import decode_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  fetch_t           mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  assign not_empty = (count != '0);
  assign full      = (count == CNT_W'(QUEUE_DEPTH));
  assign head      = mem[rd_ptr];

  // entry written at the tail
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // pointers wrap at the last entry for any depth
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count  <= count + CNT_W'(push) - CNT_W'(pop);
      // one credit back to fetch per freed entry
      credit <= pop;
    end
  end

  // fetcher only pushes with a credit in hand
  assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("inst_queue: push into full queue");

  assert property (@(posedge clk) disable iff (reset) pop |-> not_empty)
    else $error("inst_queue: pop from empty queue");

endmodule : inst_queue

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_val,
  output logic [31:0] rs2_val,
  input  logic        wb_en,
  input  logic [4:0]  wb_addr,
  input  logic [31:0] wb_data
);

  logic [31:0] regs [32];

  // writeback at the edge, x0 writes dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && (wb_addr != 5'd0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // async read, same-cycle write not bypassed
  assign rs1_val = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_val = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule : reg_file

// File: hw/uop_issue.sv
`timescale 1ns/1ps

module uop_issue #(
  parameter int EXE_CREDITS = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               not_empty,
  output logic               pop,
  input  decode_pkg::fetch_t head,
  input  decode_pkg::ctrl_t  ctrl,
  input  logic [31:0]        imm,
  input  logic [31:0]        rs1_val,
  input  logic [31:0]        rs2_val,
  input  logic               exe_credit,
  output logic               uop_valid,
  output decode_pkg::uop_t   uop
);

  localparam int CW = $clog2(EXE_CREDITS + 1);

  // free slots in the execute buffer
  logic [CW-1:0] credits;

  // issue whenever there is work and room downstream
  assign pop = not_empty && (credits != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      credits   <= CW'(EXE_CREDITS);
      uop_valid <= 1'b0;
    end else begin
      // returned credit and pop may coincide
      credits   <= credits + CW'(exe_credit) - CW'(pop);
      uop_valid <= pop;
    end
  end

  // payload only, qualified by uop_valid
  always_ff @(posedge clk) begin
    if (pop) begin
      uop.pc      <= head.pc;
      uop.ctrl    <= ctrl;
      uop.rd      <= head.instr.r_fmt.rd;
      uop.funct3  <= head.instr.r_fmt.funct3;
      uop.funct7  <= head.instr.r_fmt.funct7;
      uop.imm     <= imm;
      uop.rs1_val <= rs1_val;
      uop.rs2_val <= rs2_val;
    end
  end

  // execute never hands back more slots than it has
  assert property (@(posedge clk) disable iff (reset) credits <= CW'(EXE_CREDITS))
    else $error("uop_issue: credit count %0d above %0d", credits, EXE_CREDITS);

endmodule : uop_issue

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int QUEUE_DEPTH = 4,
  parameter int EXE_CREDITS = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               fetch_valid,
  input  decode_pkg::fetch_t fetch_data,
  output logic               fetch_credit,
  output logic               uop_valid,
  output decode_pkg::uop_t   uop,
  input  logic               exe_credit,
  input  logic               wb_en,
  input  logic [4:0]         wb_addr,
  input  logic [31:0]        wb_data
);

  import decode_pkg::*;

  fetch_t      head;
  logic        not_empty;
  logic        pop;
  ctrl_t       ctrl;
  logic [31:0] imm;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;

  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue_i (
    .clk       (clk),
    .reset     (reset),
    .push      (fetch_valid),
    .push_data (fetch_data),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .credit    (fetch_credit)
  );

  // decode works on the queue head directly
  decode_control control_i (
    .opcode (head.instr.r_fmt.opcode),
    .ctrl   (ctrl)
  );

  imm_gen imm_i (
    .instr (head.instr),
    .imm   (imm)
  );

  reg_file regs_i (
    .clk     (clk),
    .reset   (reset),
    .rs1     (head.instr.r_fmt.rs1),
    .rs2     (head.instr.r_fmt.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  uop_issue #(
    .EXE_CREDITS (EXE_CREDITS)
  ) issue_i (
    .clk        (clk),
    .reset      (reset),
    .not_empty  (not_empty),
    .pop        (pop),
    .head       (head),
    .ctrl       (ctrl),
    .imm        (imm),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .exe_credit (exe_credit),
    .uop_valid  (uop_valid),
    .uop        (uop)
  );

endmodule : decode_stage

// File: dv/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

  import decode_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int EXE_CREDITS = 2;
  localparam int N_RAND      = 96;
  localparam int N_BP        = QUEUE_DEPTH + EXE_CREDITS;
  localparam int N_TOTAL     = N_RAND + N_BP;

  logic        clk;
  logic        reset;
  logic        fetch_valid;
  fetch_t      fetch_data;
  logic        fetch_credit;
  logic        uop_valid;
  uop_t        uop;
  logic        exe_credit;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;

  // model state
  logic [15:0] lfsr_state;
  logic [31:0] model_regs [32];
  fetch_t      pending [$];
  fetch_t      scoreboard [$];
  int          fetch_cred;
  int          held;
  int          issued;
  int          credit_pulses;
  logic        withhold;
  logic [6:0]  known_ops [11] = '{R_TYPE, I_TYPE, LOAD, STORE, B_TYPE, JAL, JALR, LUI, AUIPC,
                                  SYSTEM, AMO};

  decode_stage #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .EXE_CREDITS (EXE_CREDITS)
  ) dut_i (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_data   (fetch_data),
    .fetch_credit (fetch_credit),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .exe_credit   (exe_credit),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic is_known(input logic [6:0] op);
    logic hit;
    hit = 1'b0;
    foreach (known_ops[k]) begin
      if (known_ops[k] == op) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // first eleven walk every opcode, then random mix with invalid ones
  function automatic logic [31:0] make_instr(input int idx);
    logic [6:0]  op;
    logic [3:0]  pick;
    logic [31:0] ins;
    if (idx < 11) begin
      op = known_ops[idx];
    end else begin
      pick = 4'(rand_bits(4));
      if (pick < 4'd11) begin
        op = known_ops[pick];
      end else begin
        op = 7'(rand_bits(7));
        while (is_known(op)) begin
          op = 7'(rand_bits(7));
        end
      end
    end
    ins = rand_bits(25);
    ins = {ins[24:0], op};
    // every eighth one reads x0
    if (idx % 8 == 0) begin
      ins[19:15] = 5'd0;
    end
    return ins;
  endfunction

  // control word rebuilt field by field from the opcode class
  function automatic ctrl_t model_ctrl(input logic [6:0] op);
    ctrl_t c;
    logic  known;
    known = is_known(op);
    c = '0;
    c.reg_write      = known && (op != STORE) && (op != B_TYPE);
    c.mem_write      = (op == STORE);
    c.mem_csr_to_reg = (op == LOAD) ? 2'b01 : ((op == SYSTEM) ? 2'b10 : 2'b00);
    c.branch         = (op == B_TYPE);
    c.alu_src        = op inside {I_TYPE, JALR, LOAD, STORE, JAL, LUI, AUIPC};
    c.jump           = (op == JAL) || (op == JALR);
    if ((op == R_TYPE) || (op == SYSTEM)) begin
      c.alu_op = ALU_R_TYPE;
    end else if (op == I_TYPE) begin
      c.alu_op = ALU_I_TYPE;
    end else if (op == B_TYPE) begin
      c.alu_op = ALU_B_TYPE;
    end else begin
      c.alu_op = ALU_LOAD_STORE;
    end
    c.lui          = (op == LUI);
    c.auipc        = (op == AUIPC);
    c.jal          = (op == JAL);
    c.r_type       = (op == R_TYPE);
    c.csr_type     = (op == SYSTEM);
    c.is_atomic    = (op == AMO);
    c.invalid_inst = !known;
    return c;
  endfunction

  // immediates straight from the isa bit positions
  function automatic logic [31:0] model_imm(input logic [31:0] i);
    case (i[6:0])
      I_TYPE, LOAD, JALR, SYSTEM: return {{20{i[31]}}, i[31:20]};
      STORE:                      return {{20{i[31]}}, i[31:25], i[11:7]};
      B_TYPE:                     return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      LUI, AUIPC:                 return {i[31:12], 12'h000};
      JAL:                        return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      default:                    return 32'd0;
    endcase
  endfunction

  function automatic uop_t expected_uop(input fetch_t e);
    uop_t        u;
    logic [31:0] ins;
    ins       = e.instr;
    u.pc      = e.pc;
    u.ctrl    = model_ctrl(ins[6:0]);
    u.rd      = ins[11:7];
    u.funct3  = ins[14:12];
    u.funct7  = ins[31:25];
    u.imm     = model_imm(ins);
    u.rs1_val = model_regs[ins[19:15]];
    u.rs2_val = model_regs[ins[24:20]];
    return u;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // sample registered outputs at the falling edge
  task automatic observe();
    fetch_t e;
    uop_t   x;
    if (fetch_credit) begin
      credit_pulses++;
      fetch_cred++;
      if (fetch_cred > QUEUE_DEPTH) begin
        stop_run("fetch credits came back beyond the queue depth");
      end
    end
    if (uop_valid) begin
      if (scoreboard.size() == 0) begin
        stop_run("a micro-op came out with no instruction outstanding");
      end else begin
        e = scoreboard.pop_front();
        x = expected_uop(e);
        check_value("uop.pc", uop.pc, x.pc);
        check_value("uop.ctrl", 32'(uop.ctrl), 32'(x.ctrl));
        check_value("uop.rd", 32'(uop.rd), 32'(x.rd));
        check_value("uop.funct3", 32'(uop.funct3), 32'(x.funct3));
        check_value("uop.funct7", 32'(uop.funct7), 32'(x.funct7));
        check_value("uop.imm", uop.imm, x.imm);
        check_value("uop.rs1_val", uop.rs1_val, x.rs1_val);
        check_value("uop.rs2_val", uop.rs2_val, x.rs2_val);
        issued++;
        held++;
        if (held > EXE_CREDITS) begin
          stop_run("more micro-ops in flight than execute credits");
        end
      end
    end
  endtask

  // one clock: drive on the rising edge, look on the falling edge
  task automatic step_cycle();
    fetch_t f;
    @(posedge clk);
    // push only with a fetch credit in hand
    if ((pending.size() > 0) && (fetch_cred > 0) && (rand_bits(2) != 0)) begin
      f = pending.pop_front();
      fetch_valid <= 1'b1;
      fetch_data  <= f;
      scoreboard.push_back(f);
      fetch_cred--;
    end else begin
      fetch_valid <= 1'b0;
    end
    // execute frees a slot after a random delay
    if (!withhold && (held > 0) && (rand_bits(2) == 0)) begin
      exe_credit <= 1'b1;
      held--;
    end else begin
      exe_credit <= 1'b0;
    end
    @(negedge clk);
    observe();
  endtask

  initial begin
    fetch_t      f;
    logic [31:0] v;
    lfsr_state    = 16'd1874;
    reset         = 1'b1;
    fetch_valid   = 1'b0;
    fetch_data    = '0;
    exe_credit    = 1'b0;
    wb_en         = 1'b0;
    wb_addr       = 5'd0;
    wb_data       = 32'd0;
    withhold      = 1'b0;
    fetch_cred    = QUEUE_DEPTH;
    held          = 0;
    issued        = 0;
    credit_pulses = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("uop_valid", 32'(uop_valid), 32'd0);
    check_value("fetch_credit", 32'(fetch_credit), 32'd0);
    // load phase, x0 written too but must stay zero
    for (int a = 0; a < 32; a++) begin
      @(posedge clk);
      v = rand_bits(32);
      wb_en   <= 1'b1;
      wb_addr <= 5'(a);
      wb_data <= v;
      model_regs[a] = (a == 0) ? 32'd0 : v;
    end
    @(posedge clk);
    wb_en <= 1'b0;
    // random traffic on both credit loops
    for (int i = 0; i < N_TOTAL; i++) begin
      f.pc    = 32'h0000_1000 + 32'(i * 4);
      f.instr = make_instr(i);
      if (i == N_RAND) begin
        while (issued < N_RAND) step_cycle();
        while (held > 0) step_cycle();
        withhold = 1'b1;
      end
      pending.push_back(f);
    end
    // back-pressure, only the initial execute credits get through
    while (pending.size() > 0) step_cycle();
    repeat (8) step_cycle();
    check_value("uops under back-pressure", 32'(issued - N_RAND), 32'(EXE_CREDITS));
    check_value("fetch credits held", 32'(fetch_cred), 32'd0);
    withhold = 1'b0;
    while (issued < N_TOTAL) step_cycle();
    while (held > 0) step_cycle();
    check_value("fetch_credit pulses", 32'(credit_pulses), 32'(issued));
    check_value("fetch credits at end", 32'(fetch_cred), 32'(QUEUE_DEPTH));
    $display("Done: no errors");
    $finish;
  end

  // watchdog, about 20 cycles per instruction plus margin for reset and load
  initial begin
    repeat ((N_TOTAL * 20) + 200) @(posedge clk);
    stop_run("the run timed out before all micro-ops were issued");
  end

endmodule : decode_stage_tb

// File: decode_stage.f
hw/decode_pkg.sv
hw/decode_control.sv
hw/imm_gen.sv
hw/inst_queue.sv
hw/reg_file.sv
hw/uop_issue.sv
hw/decode_stage.sv
dv/decode_stage_tb.sv

// File: run.sh
#!/bin/sh
# build the decode stage testbench with verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module decode_stage_tb -f decode_stage.f \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vdecode_stage_tb > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || grep -q "Done: no errors" sim.log
